// ==== Makefile ====
# Verilator flow for the dual-channel AGC, every variable can be set on the command line
VERILATOR ?= verilator
TOP       ?= dualChannelAgcTb
RTL_TOP   ?= dualChannelAgc
FILELIST  ?= dualChannelAgc.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Pass only when the pass message shows up in the simulation output
run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== dualChannelAgc.f ====
+incdir+include
logic/agcDspPkg.sv
logic/agcRegPkg.sv
logic/magEstimator.sv
logic/log2Converter.sv
logic/agcRegs.sv
logic/agcLoopFilter.sv
logic/dualChannelAgc.sv
verif/dualChannelAgcTb.sv

// ==== include/agc_defs.svh ====
// Width and coefficient macros for the dual-channel AGC, included by its packages and RTL
`ifndef AGC_DEFS_SVH
`define AGC_DEFS_SVH

// I/Q sample width, two's complement
`define AGC_SAMPLE_W 18

// Linear magnitude width
`define AGC_LEVEL_W 16

// Log2 level width, 4 integer bits over 8 fraction bits
`define AGC_LOG_W 12

// Gain word width seen by the downstream scaler
`define AGC_GAIN_W 21

// Loop integrator width
`define AGC_ACC_W 32

// Magnitude weights scaled by 2^17, min peak error pair
`define AGC_ALPHA 125886
`define AGC_BETA 52144

// APB address width
`define APB_ADDR_W 8

`endif

// ==== logic/agcDspPkg.sv ====
// Datapath types shared by the AGC estimator, log converter and loop filter
`include "agc_defs.svh"

package agcDspPkg;

    // Raw I or Q sample from the channel filter
    typedef logic signed [`AGC_SAMPLE_W-1:0] sampleT;

    // Linear magnitude estimate
    typedef logic [`AGC_LEVEL_W-1:0] levelT;

    // Log2 level, integer part in the top 4 bits
    typedef logic [`AGC_LOG_W-1:0] logLevelT;

    // Gain word, accumulator bits 30:10
    typedef logic [`AGC_GAIN_W-1:0] gainT;

    // Loop mode
    // Hold forces the gain to the initial value, track closes the loop
    typedef enum logic {
        agcHold  = 1'b0,
        agcTrack = 1'b1
    } loopModeT;

endpackage

// ==== logic/agcLoopFilter.sv ====
// Shared AGC loop filter, two clamped integrators driving gain words and squelch flags
`include "agc_defs.svh"

module agcLoopFilter (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 sampleEn,
    input  agcDspPkg::logLevelT  logLevel0,
    input  agcDspPkg::logLevelT  logLevel1,
    input  agcDspPkg::loopModeT  loopMode,
    input  agcRegPkg::loopShiftT loopShift,
    input  agcDspPkg::logLevelT  refLevel,
    input  agcDspPkg::logLevelT  squelchThresh,
    input  agcDspPkg::gainT      gainInit,
    output agcDspPkg::gainT      agcGain0,
    output agcDspPkg::gainT      agcGain1,
    output logic                 squelch0,
    output logic                 squelch1
);

    localparam int accW = `AGC_ACC_W;
    // Two guard bits catch both overflow and underflow
    localparam int sumW = accW + 2;
    // Level difference needs one sign bit
    localparam int errW = `AGC_LOG_W + 1;
    // Gain sits just under the unused accumulator MSB
    localparam int gainLsb = accW - 1 - `AGC_GAIN_W;
    localparam logic signed [sumW-1:0] accLimit = sumW'({(accW-1){1'b1}});

    logic [accW-1:0] acc0;
    logic [accW-1:0] acc1;
    logic [accW-1:0] holdValue;

    // One tracking update with clamp to 0 .. 2^31-1
    function automatic logic [accW-1:0] trackStep(
        input logic [accW-1:0]          acc,
        input agcDspPkg::logLevelT      lvl,
        input agcDspPkg::logLevelT      target,
        input agcRegPkg::loopShiftT     shift
    );
        logic signed [errW-1:0] err;
        logic signed [sumW-1:0] step;
        logic signed [sumW-1:0] sum;
        logic [accW-1:0]        result;
        // Positive error raises the gain
        err = $signed({1'b0, target}) - $signed({1'b0, lvl});
        step = sumW'(err) <<< shift;
        sum = $signed(sumW'(acc)) + step;
        if (sum < 0) begin
            result = '0;
        end else if (sum > accLimit) begin
            result = accLimit[accW-1:0];
        end else begin
            result = sum[accW-1:0];
        end
        return result;
    endfunction

    // Initial gain aligned to the gain field
    assign holdValue = accW'({gainInit, {gainLsb{1'b0}}});

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            acc0 <= '0;
            acc1 <= '0;
            squelch0 <= 1'b0;
            squelch1 <= 1'b0;
        end else if (sampleEn) begin
            if (loopMode == agcDspPkg::agcTrack) begin
                acc0 <= trackStep(acc0, logLevel0, refLevel, loopShift);
                acc1 <= trackStep(acc1, logLevel1, refLevel, loopShift);
            end else begin
                acc0 <= holdValue;
                acc1 <= holdValue;
            end
            // Squelch when the channel sits under the threshold
            squelch0 <= (logLevel0 < squelchThresh);
            squelch1 <= (logLevel1 < squelchThresh);
        end
    end

    assign agcGain0 = acc0[gainLsb +: `AGC_GAIN_W];
    assign agcGain1 = acc1[gainLsb +: `AGC_GAIN_W];

endmodule

// ==== logic/agcRegPkg.sv ====
// APB register map and control field types for the AGC register block
`include "agc_defs.svh"

package agcRegPkg;

    // Word offsets of the register map
    typedef enum logic [`APB_ADDR_W-1:0] {
        ctrlAddr     = 8'h00,
        refAddr      = 8'h04,
        squelchAddr  = 8'h08,
        gainInitAddr = 8'h0C,
        level0Addr   = 8'h10,
        level1Addr   = 8'h14
    } regAddrT;

    // Loop shift field of CTRL
    typedef logic [3:0] loopShiftT;

    // CTRL bit positions
    localparam int ctrlModeBit  = 0;
    localparam int ctrlShiftLsb = 1;

endpackage

// ==== logic/agcRegs.sv ====
// APB slave for the AGC, holds loop controls and returns the two log levels on reads
`include "agc_defs.svh"

module agcRegs (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`APB_ADDR_W-1:0]  paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  agcDspPkg::logLevelT     level0,
    input  agcDspPkg::logLevelT     level1,
    output agcDspPkg::loopModeT     loopMode,
    output agcRegPkg::loopShiftT    loopShift,
    output agcDspPkg::logLevelT     refLevel,
    output agcDspPkg::logLevelT     squelchThresh,
    output agcDspPkg::gainT         gainInit
);

    localparam int shiftW = $bits(agcRegPkg::loopShiftT);

    agcRegPkg::regAddrT regAddr;
    logic               access;
    logic               addrValid;
    logic               addrReadOnly;
    logic               wrEn;
    logic [31:0]        readData;

    assign regAddr = agcRegPkg::regAddrT'(paddr);
    assign access = psel && penable;

    // Address decode and read mux
    always_comb begin
        addrValid = 1'b1;
        addrReadOnly = 1'b0;
        readData = '0;
        case (regAddr)
            agcRegPkg::ctrlAddr: begin
                readData[agcRegPkg::ctrlModeBit] = loopMode;
                readData[agcRegPkg::ctrlShiftLsb +: shiftW] = loopShift;
            end
            agcRegPkg::refAddr:      readData = 32'(refLevel);
            agcRegPkg::squelchAddr:  readData = 32'(squelchThresh);
            agcRegPkg::gainInitAddr: readData = 32'(gainInit);
            agcRegPkg::level0Addr: begin
                readData = 32'(level0);
                addrReadOnly = 1'b1;
            end
            agcRegPkg::level1Addr: begin
                readData = 32'(level1);
                addrReadOnly = 1'b1;
            end
            default: addrValid = 1'b0;
        endcase
    end

    // Zero wait states, errors only in the access cycle
    assign pready = 1'b1;
    assign prdata = readData;
    assign pslverr = access && (!addrValid || (pwrite && addrReadOnly));
    assign wrEn = access && pwrite && addrValid && !addrReadOnly;

    // Writable registers, full-word writes on the access edge
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            loopMode <= agcDspPkg::agcHold;
            loopShift <= '0;
            refLevel <= '0;
            squelchThresh <= '0;
            gainInit <= '0;
        end else if (wrEn) begin
            case (regAddr)
                agcRegPkg::ctrlAddr: begin
                    loopMode <= agcDspPkg::loopModeT'(pwdata[agcRegPkg::ctrlModeBit]);
                    loopShift <= pwdata[agcRegPkg::ctrlShiftLsb +: shiftW];
                end
                agcRegPkg::refAddr:      refLevel <= pwdata[`AGC_LOG_W-1:0];
                agcRegPkg::squelchAddr:  squelchThresh <= pwdata[`AGC_LOG_W-1:0];
                agcRegPkg::gainInitAddr: gainInit <= pwdata[`AGC_GAIN_W-1:0];
                default: ;
            endcase
        end
    end

endmodule

// ==== logic/dualChannelAgc.sv ====
// Dual-channel AGC top level, two magnitude and log paths feeding one loop filter under APB
`include "agc_defs.svh"

module dualChannelAgc (
    input  logic                   clk,
    input  logic                   arstN,
    // APB slave
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    // Sample stream
    input  logic                   sampleEn,
    input  agcDspPkg::sampleT      iIn0,
    input  agcDspPkg::sampleT      qIn0,
    input  agcDspPkg::sampleT      iIn1,
    input  agcDspPkg::sampleT      qIn1,
    // Loop outputs
    output agcDspPkg::gainT        agcGain0,
    output agcDspPkg::gainT        agcGain1,
    output logic                   squelch0,
    output logic                   squelch1
);

    // Linear and log levels per channel
    agcDspPkg::levelT     linLevel0;
    agcDspPkg::levelT     linLevel1;
    agcDspPkg::logLevelT  logLevel0;
    agcDspPkg::logLevelT  logLevel1;

    // Loop controls from the register block
    agcDspPkg::loopModeT  loopMode;
    agcRegPkg::loopShiftT loopShift;
    agcDspPkg::logLevelT  refLevel;
    agcDspPkg::logLevelT  squelchThresh;
    agcDspPkg::gainT      gainInit;

    // Channel 0, two strobes then one
    magEstimator magEst0 (
        .clk(clk), .arstN(arstN), .sampleEn(sampleEn),
        .iIn(iIn0), .qIn(qIn0), .level(linLevel0)
    );
    log2Converter logConv0 (
        .clk(clk), .arstN(arstN), .sampleEn(sampleEn),
        .level(linLevel0), .logLevel(logLevel0)
    );

    // Channel 1
    magEstimator magEst1 (
        .clk(clk), .arstN(arstN), .sampleEn(sampleEn),
        .iIn(iIn1), .qIn(qIn1), .level(linLevel1)
    );
    log2Converter logConv1 (
        .clk(clk), .arstN(arstN), .sampleEn(sampleEn),
        .level(linLevel1), .logLevel(logLevel1)
    );

    agcRegs regs (
        .clk(clk), .arstN(arstN),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .level0(logLevel0), .level1(logLevel1),
        .loopMode(loopMode), .loopShift(loopShift), .refLevel(refLevel),
        .squelchThresh(squelchThresh), .gainInit(gainInit)
    );

    // Last strobe of latency, four in total
    agcLoopFilter loopFilter (
        .clk(clk), .arstN(arstN), .sampleEn(sampleEn),
        .logLevel0(logLevel0), .logLevel1(logLevel1),
        .loopMode(loopMode), .loopShift(loopShift), .refLevel(refLevel),
        .squelchThresh(squelchThresh), .gainInit(gainInit),
        .agcGain0(agcGain0), .agcGain1(agcGain1),
        .squelch0(squelch0), .squelch1(squelch1)
    );

endmodule

// ==== logic/log2Converter.sv ====
// Linear to log2 conversion of a level, leading-one position plus 8 fraction bits, one strobe
`include "agc_defs.svh"

module log2Converter (
    input  logic                clk,
    input  logic                arstN,
    input  logic                sampleEn,
    input  agcDspPkg::levelT    level,
    output agcDspPkg::logLevelT logLevel
);

    // Integer part holds the bit position, rest is fraction
    localparam int posW = $clog2(`AGC_LEVEL_W);
    localparam int fracW = `AGC_LOG_W - posW;
    localparam int extW = `AGC_LEVEL_W + fracW;

    logic [posW-1:0]  onePos;
    logic [extW-1:0]  extLevel;
    logic [extW-1:0]  aligned;
    logic [fracW-1:0] frac;
    logic             levelZero;

    // Leading-one detector
    // Scanning upward, the last set bit wins
    always_comb begin
        onePos = '0;
        for (int b = 0; b < `AGC_LEVEL_W; b++) begin
            if (level[b]) begin
                onePos = posW'(b);
            end
        end
    end

    // Zero padding below the level covers positions under 8
    assign extLevel = {level, {fracW{1'b0}}};

    // Leading one lands at bit fracW, fraction sits just under it
    assign aligned = extLevel >> onePos;
    assign frac = aligned[fracW-1:0];

    assign levelZero = (level == '0);

    // Output register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            logLevel <= '0;
        end else if (sampleEn) begin
            if (levelZero) begin
                logLevel <= '0;
            end else begin
                // p * 256 + fraction
                logLevel <= {onePos, frac};
            end
        end
    end

endmodule

// ==== logic/magEstimator.sv ====
// Per-channel magnitude estimator, alpha*max + beta*min over a two-strobe pipeline
`include "agc_defs.svh"

module magEstimator (
    input  logic              clk,
    input  logic              arstN,
    input  logic              sampleEn,
    input  agcDspPkg::sampleT iIn,
    input  agcDspPkg::sampleT qIn,
    output agcDspPkg::levelT  level
);

    // Magnitude of one component fits one bit less than the sample
    localparam int magW = `AGC_SAMPLE_W - 1;
    localparam int prodW = 2 * magW;
    // One carry bit over the magnitude for the weighted sum
    localparam int sumW = magW + 1;
    // Weights are fractions scaled by 2^17
    localparam int coefShift = 17;
    localparam logic [magW-1:0] alphaCoef = magW'(`AGC_ALPHA);
    localparam logic [magW-1:0] betaCoef = magW'(`AGC_BETA);
    localparam logic [sumW-1:0] levelMax = sumW'({`AGC_LEVEL_W{1'b1}});

    logic [magW-1:0]  absI;
    logic [magW-1:0]  absQ;
    logic [magW-1:0]  maxMag;
    logic [magW-1:0]  minMag;
    logic [prodW-1:0] maxProd;
    logic [prodW-1:0] minProd;
    logic [sumW-1:0]  weightSum;

    // Absolute value, most negative sample clips to full scale
    function automatic logic [magW-1:0] absSat(input agcDspPkg::sampleT s);
        logic [magW-1:0] mag;
        if (s[magW] && (s[magW-1:0] == '0)) begin
            mag = '1;
        end else if (s[magW]) begin
            mag = magW'(-s);
        end else begin
            mag = s[magW-1:0];
        end
        return mag;
    endfunction

    assign absI = absSat(iIn);
    assign absQ = absSat(qIn);

    // Stage 1, sort the two magnitudes
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            maxMag <= '0;
            minMag <= '0;
        end else if (sampleEn) begin
            if (absI > absQ) begin
                maxMag <= absI;
                minMag <= absQ;
            end else begin
                maxMag <= absQ;
                minMag <= absI;
            end
        end
    end

    // Weighted terms, each floored after the 2^17 scale
    assign maxProd = maxMag * alphaCoef;
    assign minProd = minMag * betaCoef;
    assign weightSum = sumW'(maxProd >> coefShift) + sumW'(minProd >> coefShift);

    // Stage 2, saturate to the 16-bit level
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            level <= '0;
        end else if (sampleEn) begin
            if (weightSum > levelMax) begin
                level <= '1;
            end else begin
                level <= weightSum[`AGC_LEVEL_W-1:0];
            end
        end
    end

endmodule

// ==== verif/dualChannelAgcTb.sv ====
// Self-checking testbench for the dual-channel AGC, top module of the simulation build
`include "agc_defs.svh"

module dualChannelAgcTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clkPeriod = 4;
    localparam int numHand = 6;
    localparam int numEntries = 12;
    localparam int holdStrobes = 8;
    // Budget of 200 cycles per table entry covers the tracking runs too
    localparam int timeoutCycles = numEntries * 200;
    localparam agcDspPkg::gainT gainMax = '1;

    // One table row, two channels of I/Q plus register settings and expected log levels
    typedef struct packed {
        agcDspPkg::sampleT   i0;
        agcDspPkg::sampleT   q0;
        agcDspPkg::sampleT   i1;
        agcDspPkg::sampleT   q1;
        agcDspPkg::logLevelT thresh;
        agcDspPkg::gainT     gainInit;
        agcDspPkg::logLevelT exp0;
        agcDspPkg::logLevelT exp1;
    } stimT;

    logic clk = 1'b0;
    logic arstN;
    logic psel;
    logic penable;
    logic pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic sampleEn;
    agcDspPkg::sampleT iIn0;
    agcDspPkg::sampleT qIn0;
    agcDspPkg::sampleT iIn1;
    agcDspPkg::sampleT qIn1;
    agcDspPkg::gainT agcGain0;
    agcDspPkg::gainT agcGain1;
    logic squelch0;
    logic squelch1;

    int seed = 32'h1310_419c;
    int enRand;
    int errCount = 0;
    stimT tab [numEntries];

    dualChannelAgc uut (
        .clk(clk), .arstN(arstN),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .sampleEn(sampleEn), .iIn0(iIn0), .qIn0(qIn0), .iIn1(iIn1), .qIn1(qIn1),
        .agcGain0(agcGain0), .agcGain1(agcGain1), .squelch0(squelch0), .squelch1(squelch1)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // Sample strobe, high on about half the cycles
    always @(negedge clk) begin
        enRand = $random(seed);
        sampleEn = enRand[0];
    end

    task automatic stopRun();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] want);
        errCount++;
        $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
        stopRun();
    endtask

    task automatic checkLog(input string what, input agcDspPkg::logLevelT got,
                            input agcDspPkg::logLevelT want);
        if (got !== want) begin
            reportMismatch(what, 32'(got), 32'(want));
        end
    endtask

    task automatic checkGain(input string what, input agcDspPkg::gainT got,
                             input agcDspPkg::gainT want);
        if (got !== want) begin
            reportMismatch(what, 32'(got), 32'(want));
        end
    endtask

    task automatic checkShift(input string what, input agcRegPkg::loopShiftT got,
                              input agcRegPkg::loopShiftT want);
        if (got !== want) begin
            reportMismatch(what, 32'(got), 32'(want));
        end
    endtask

    task automatic checkBit(input string what, input logic got, input logic want);
        if (got !== want) begin
            reportMismatch(what, 32'(got), 32'(want));
        end
    endtask

    // Magnitude rule, floored weights and 16-bit saturation
    function automatic agcDspPkg::levelT magModel(input int i, input int q);
        int fullScale;
        int ai;
        int aq;
        longint sum;
        fullScale = (1 << (`AGC_SAMPLE_W - 1)) - 1;
        ai = (i < 0) ? -i : i;
        aq = (q < 0) ? -q : q;
        // Most negative sample clips to full scale
        ai = (ai > fullScale) ? fullScale : ai;
        aq = (aq > fullScale) ? fullScale : aq;
        sum = ((longint'((ai > aq) ? ai : aq) * `AGC_ALPHA) >> 17)
            + ((longint'((ai > aq) ? aq : ai) * `AGC_BETA) >> 17);
        return (sum > 65535) ? 16'hFFFF : agcDspPkg::levelT'(sum);
    endfunction

    // Log rule, bit position times 256 plus the next 8 bits down
    function automatic agcDspPkg::logLevelT logModel(input agcDspPkg::levelT lvl);
        int p;
        int frac;
        p = 0;
        for (int b = 0; b < `AGC_LEVEL_W; b++) begin
            if (lvl[b]) begin
                p = b;
            end
        end
        frac = ((int'(lvl) * 256) >> p) % 256;
        return (lvl == 0) ? '0 : agcDspPkg::logLevelT'(p * 256 + frac);
    endfunction

    // Random sample at a random scale so the levels spread over the log range
    function automatic agcDspPkg::sampleT randSample();
        agcDspPkg::sampleT s;
        int sh;
        s = agcDspPkg::sampleT'($random(seed));
        sh = $unsigned($random(seed)) % 14;
        return s >>> sh;
    endfunction

    task automatic fillTable();
        // Zero, full-scale negative, I over Q, Q over I, saturation
        tab[0] = '{18'sd0, 18'sd0, 18'sd1000, 18'sd200, 12'h100, 21'h000400, 12'h000, 12'hA03};
        tab[1] = '{18'h20000, 18'h20000, -18'sd300, 18'sd5000, 12'hFFF, 21'h1FFFFF,
                   12'hFFF, 12'hC33};
        tab[2] = '{-18'sd300, 18'sd5000, 18'sd70000, 18'sd0, 12'hC34, 21'h0ABCDE,
                   12'hC33, 12'hFFF};
        tab[3] = '{18'sd5, -18'sd3, 18'h20000, 18'sd0, 12'h240, 21'h000001, 12'h240, 12'hFFF};
        tab[4] = '{18'sd200, 18'sd1000, 18'sd5, -18'sd3, 12'h300, 21'h155555, 12'hA03, 12'h240};
        tab[5] = '{18'sd0, 18'sd0, 18'sd0, 18'sd0, 12'h000, 21'h000000, 12'h000, 12'h000};
        for (int k = numHand; k < numEntries; k++) begin
            tab[k].i0 = randSample();
            tab[k].q0 = randSample();
            tab[k].i1 = randSample();
            tab[k].q1 = randSample();
            tab[k].thresh = agcDspPkg::logLevelT'($random(seed));
            tab[k].gainInit = agcDspPkg::gainT'($random(seed));
            tab[k].exp0 = logModel(magModel(tab[k].i0, tab[k].q0));
            tab[k].exp1 = logModel(magModel(tab[k].i1, tab[k].q1));
        end
    endtask

    // Setup then access cycle, read data taken mid access cycle
    task automatic apbXfer(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err = pslverr;
        // Zero wait states, so the access cycle always completes
        checkBit("pready in access cycle", pready, 1'b1);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apbWrite(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data,
                            input logic expErr);
        logic [31:0] rdata;
        logic err;
        apbXfer(1'b1, addr, data, rdata, err);
        checkBit("pslverr on write", err, expErr);
    endtask

    task automatic apbRead(input logic [`APB_ADDR_W-1:0] addr, output logic [31:0] data,
                           input logic expErr);
        logic err;
        apbXfer(1'b0, addr, 32'h0, data, err);
        checkBit("pslverr on read", err, expErr);
    endtask

    // Count strobes seen at the rising edge, leave on a falling edge
    task automatic waitStrobes(input int n);
        int cnt;
        cnt = 0;
        while (cnt < n) begin
            @(posedge clk);
            if (sampleEn) begin
                cnt++;
            end
        end
        @(negedge clk);
    endtask

    task automatic driveSamples(input stimT s);
        @(negedge clk);
        iIn0 = s.i0;
        qIn0 = s.q0;
        iIn1 = s.i1;
        qIn1 = s.q1;
    endtask

    // Watchdog
    initial begin
        #(timeoutCycles * clkPeriod);
        $display("Timeout: the run did not finish within %0d clock cycles", timeoutCycles);
        stopRun();
    end

    initial begin
        logic [31:0] rd;
        agcDspPkg::gainT prev0;
        agcDspPkg::gainT prev1;
        arstN = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        sampleEn = 1'b0;
        iIn0 = '0;
        qIn0 = '0;
        iIn1 = '0;
        qIn1 = '0;
        fillTable();
        repeat (10) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        // Register access, rejected transfers leave the contents alone
        apbWrite(agcRegPkg::refAddr, 32'h0000_0A5C, 1'b0);
        apbWrite(agcRegPkg::squelchAddr, 32'h0000_0123, 1'b0);
        // Upper bits set so the zero extension on readback is visible
        apbWrite(agcRegPkg::gainInitAddr, 32'hFFF5_5AA5, 1'b0);
        apbWrite(agcRegPkg::ctrlAddr, 32'h0000_0014, 1'b0);
        apbRead(8'h18, rd, 1'b1);
        apbWrite(8'h06, 32'hFFFF_FFFF, 1'b1);
        apbWrite(agcRegPkg::level0Addr, 32'hFFFF_FFFF, 1'b1);
        apbRead(agcRegPkg::level0Addr, rd, 1'b0);
        checkLog("LEVEL0 after rejected write", rd[11:0], 12'h000);
        apbRead(agcRegPkg::refAddr, rd, 1'b0);
        checkLog("REF readback", rd[11:0], 12'hA5C);
        apbRead(agcRegPkg::squelchAddr, rd, 1'b0);
        checkLog("SQUELCH readback", rd[11:0], 12'h123);
        apbRead(agcRegPkg::gainInitAddr, rd, 1'b0);
        checkGain("GAIN_INIT readback", rd[20:0], 21'h155AA5);
        checkBit("GAIN_INIT upper bits zero", rd[31:21] == '0, 1'b1);
        apbRead(agcRegPkg::ctrlAddr, rd, 1'b0);
        checkBit("CTRL mode", rd[0], 1'b0);
        checkShift("CTRL shift", rd[4:1], 4'hA);

        // Table, levels and squelch per channel with the loop in hold
        for (int k = 0; k < numEntries; k++) begin
            apbWrite(agcRegPkg::squelchAddr, 32'(tab[k].thresh), 1'b0);
            apbWrite(agcRegPkg::gainInitAddr, 32'(tab[k].gainInit), 1'b0);
            driveSamples(tab[k]);
            waitStrobes(holdStrobes);
            checkBit("squelch0", squelch0, tab[k].exp0 < tab[k].thresh);
            checkBit("squelch1", squelch1, tab[k].exp1 < tab[k].thresh);
            checkGain("gain0 in hold", agcGain0, tab[k].gainInit);
            checkGain("gain1 in hold", agcGain1, tab[k].gainInit);
            apbRead(agcRegPkg::level0Addr, rd, 1'b0);
            checkLog("LEVEL0", rd[11:0], tab[k].exp0);
            apbRead(agcRegPkg::level1Addr, rd, 1'b0);
            checkLog("LEVEL1", rd[11:0], tab[k].exp1);
        end

        // Silent inputs under a high reference, gains climb to full scale
        driveSamples('0);
        apbWrite(agcRegPkg::refAddr, 32'h0000_0FFF, 1'b0);
        apbWrite(agcRegPkg::ctrlAddr, 32'h0000_001F, 1'b0);
        prev0 = agcGain0;
        prev1 = agcGain1;
        while (agcGain0 != gainMax || agcGain1 != gainMax) begin
            @(negedge clk);
            checkBit("gain0 never falls while tracking up", agcGain0 >= prev0, 1'b1);
            checkBit("gain1 never falls while tracking up", agcGain1 >= prev1, 1'b1);
            prev0 = agcGain0;
            prev1 = agcGain1;
        end

        // Full-scale inputs over a zero reference, gains drain to 0
        apbWrite(agcRegPkg::refAddr, 32'h0, 1'b0);
        driveSamples('{18'h1FFFF, 18'h1FFFF, 18'h1FFFF, 18'h1FFFF, 12'h0, 21'h0, 12'h0, 12'h0});
        while (agcGain0 != '0 || agcGain1 != '0) begin
            @(negedge clk);
            checkBit("gain0 never rises while tracking down", agcGain0 <= prev0, 1'b1);
            checkBit("gain1 never rises while tracking down", agcGain1 <= prev1, 1'b1);
            prev0 = agcGain0;
            prev1 = agcGain1;
        end

        if (errCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
